//--- rtl/ldpc_cnode_pkg.sv
// ------------------------------
// shared widths, normalization factor and types
// for the min-sum check-node unit
// ------------------------------

package ldpc_cnode_pkg;

  // ------------------------------
  // sizes
  // ------------------------------

  localparam int cZC           = 8;               // lanes = one circulant row
  localparam int cNODE_W       = 5;               // two's complement message
  localparam int cMAG_W        = cNODE_W - 1;     // magnitude, saturates at 15
  localparam int cROW_MAX      = 8;               // beats per row at most
  localparam int cIDX_W        = $clog2(cROW_MAX);
  localparam int cSHIFT_W      = $clog2(cZC);     // lane count is a power of two
  localparam int cFIFO_DEPTH_W = 4;               // 16 entries, two rows in flight
  localparam int cADDR_W       = 8;

  // normalized magnitude = mag * cNORM_FACTOR / 2**cNORM_SHIFT, truncated
  localparam int cNORM_FACTOR  = 6;
  localparam int cNORM_SHIFT   = 3;

  // ------------------------------
  // types
  // ------------------------------

  typedef logic signed [cNODE_W-1 : 0]  node_t;
  typedef logic        [cMAG_W-1 : 0]   mag_t;
  typedef node_t       [cZC-1 : 0]      znode_t;  // all lanes of one beat
  typedef logic        [cZC-1 : 0]      zdat_t;   // one bit per lane
  typedef logic        [cSHIFT_W-1 : 0] shift_t;
  typedef logic        [cIDX_W-1 : 0]   idx_t;
  typedef logic        [cADDR_W-1 : 0]  addr_t;

  // input shifter payload, message with its hard decision on top
  typedef struct packed {
    logic  hd;
    node_t node;
  } ibs_elem_t;

endpackage

//--- rtl/ldpc_barrel_shifter.sv
// ------------------------------
// lane rotator with one register stage
// ------------------------------

module ldpc_barrel_shifter
  import ldpc_cnode_pkg::*;
#(
  parameter type elem_t   = node_t,
  parameter bit  pR_SHIFT = 1'b0    // 0 : rotate left, 1 : rotate right
) (
  input  logic   iclk,
  input  logic   ireset,
  input  logic   ival,
  input  elem_t  idat [cZC],
  input  shift_t ishift,
  output logic   oval,
  output elem_t  odat [cZC]
);

  elem_t rot [cZC];

  // left : lane i takes lane i+shift, right undoes it with lane i-shift
  always_comb begin : rot_sel
    shift_t sel;
    for (int i = 0; i < cZC; i++) begin
      sel    = pR_SHIFT ? (shift_t'(i) - ishift) : (shift_t'(i) + ishift); // wraps mod cZC
      rot[i] = idat[sel];
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval <= 1'b0;
    end else begin
      oval <= ival;
    end
  end

  always_ff @(posedge iclk) begin
    odat <= rot;  // payload, qualified by oval
  end

endmodule

//--- rtl/ldpc_sort_engine.sv
// ------------------------------
// per-lane min1/min2/index/sign product tracker
// results latched at the end of each row
// ------------------------------

module ldpc_sort_engine
  import ldpc_cnode_pkg::*;
(
  input  logic  iclk,
  input  logic  ireset,
  input  logic  ival,
  input  logic  isop,
  input  logic  ieop,
  input  node_t ivnode,
  output logic  odone,
  output mag_t  omin1,
  output mag_t  omin2,
  output idx_t  omin1_idx,
  output logic  osign,
  output idx_t  olen
);

  // running row state
  mag_t r_min1;
  mag_t r_min2;
  idx_t r_idx;
  logic r_sign;
  idx_t r_cnt;      // beat index of the incoming beat

  // state seen by this beat, row start restarts it
  mag_t cur_min1;
  mag_t cur_min2;
  idx_t cur_idx;
  logic cur_sign;
  idx_t cur_cnt;

  mag_t vmag;
  node_t vneg;
  mag_t n_min1;
  mag_t n_min2;
  idx_t n_idx;
  logic n_sign;

  // ------------------------------
  // magnitude with -16 saturated to 15
  // ------------------------------

  assign vneg = -ivnode;

  always_comb begin
    if (!ivnode[cNODE_W-1]) begin
      vmag = ivnode[cMAG_W-1 : 0];
    end else if (ivnode[cMAG_W-1 : 0] == '0) begin
      vmag = '1;                                   // most negative code
    end else begin
      vmag = vneg[cMAG_W-1 : 0];
    end
  end

  // ------------------------------
  // min update
  // ------------------------------

  always_comb begin
    cur_min1 = isop ? '1   : r_min1;
    cur_min2 = isop ? '1   : r_min2;
    cur_idx  = isop ? '0   : r_idx;
    cur_sign = isop ? 1'b0 : r_sign;
    cur_cnt  = isop ? '0   : r_cnt;
    n_min1   = cur_min1;
    n_min2   = cur_min2;
    n_idx    = cur_idx;
    n_sign   = cur_sign ^ ivnode[cNODE_W-1];     // product of signs
    if (vmag < cur_min1) begin                   // strict, a tie keeps the earlier index
      n_min2 = cur_min1;
      n_min1 = vmag;
      n_idx  = cur_cnt;
    end else if (vmag < cur_min2) begin
      n_min2 = vmag;
    end
  end

  always_ff @(posedge iclk) begin
    if (ival) begin
      r_min1 <= n_min1;
      r_min2 <= n_min2;
      r_idx  <= n_idx;
      r_sign <= n_sign;
      r_cnt  <= cur_cnt + 1'b1;
    end
    if (ival && ieop) begin                      // held until the next row ends
      omin1     <= n_min1;
      omin2     <= n_min2;
      omin1_idx <= n_idx;
      osign     <= n_sign;
      olen      <= cur_cnt;                      // row length minus one
    end
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      odone <= 1'b0;
    end else begin
      odone <= ival & ieop;
    end
  end

endmodule

//--- rtl/ldpc_syndrome_count.sv
// ------------------------------
// per-lane hard decision parity over a row
// and the sticky decoder failure flag
// ------------------------------

module ldpc_syndrome_count
  import ldpc_cnode_pkg::*;
(
  input  logic  iclk,
  input  logic  ireset,
  input  logic  istart,
  input  logic  ival,
  input  logic  isop,
  input  logic  ieop,
  input  zdat_t ivnode_hd,
  output logic  odecfail
);

  zdat_t par;       // running parity per lane
  zdat_t par_nxt;

  assign par_nxt = (isop ? '0 : par) ^ ivnode_hd;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      par      <= '0;
      odecfail <= 1'b0;
    end else begin
      if (ival) begin
        par <= par_nxt;
      end
      // new iteration clears the flag, otherwise any odd lane sticks
      if (istart) begin
        odecfail <= 1'b0;
      end else if (ival && ieop) begin
        odecfail <= odecfail | (|par_nxt);
      end
    end
  end

endmodule

//--- rtl/ldpc_vnode_fifo.sv
// ------------------------------
// register array FIFO for per-beat signs and shift
// one cycle read latency
// ------------------------------

module ldpc_vnode_fifo
  import ldpc_cnode_pkg::*;
(
  input  logic   iclk,
  input  logic   ireset,
  input  logic   iclear,
  input  logic   iwrite,
  input  zdat_t  iwsign,
  input  shift_t iwshift,
  input  logic   iread,
  output logic   orval,
  output zdat_t  orsign,
  output shift_t orshift,
  output logic   oempty
);

  localparam int cDEPTH = 2 ** cFIFO_DEPTH_W;

  zdat_t  mem_sign  [cDEPTH];
  shift_t mem_shift [cDEPTH];

  // extra msb tells full from empty
  logic [cFIFO_DEPTH_W : 0] wptr;
  logic [cFIFO_DEPTH_W : 0] rptr;
  logic                     rd_en;

  assign oempty = (wptr == rptr);
  assign rd_en  = iread & ~oempty;   // reading an empty FIFO is ignored

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wptr  <= '0;
      rptr  <= '0;
      orval <= 1'b0;
    end else if (iclear) begin
      wptr  <= '0;
      rptr  <= '0;
      orval <= 1'b0;
    end else begin
      if (iwrite) begin
        wptr <= wptr + 1'b1;
      end
      if (rd_en) begin
        rptr <= rptr + 1'b1;
      end
      orval <= rd_en;
    end
  end

  always_ff @(posedge iclk) begin
    if (iwrite) begin
      mem_sign [wptr[cFIFO_DEPTH_W-1 : 0]] <= iwsign;
      mem_shift[wptr[cFIFO_DEPTH_W-1 : 0]] <= iwshift;
    end
    if (rd_en) begin
      orsign  <= mem_sign [rptr[cFIFO_DEPTH_W-1 : 0]];
      orshift <= mem_shift[rptr[cFIFO_DEPTH_W-1 : 0]];
    end
  end

endmodule

//--- rtl/ldpc_cnode_restore.sv
// ------------------------------
// FIFO read control and per-lane check-to-variable
// message rebuild with normalization
// ------------------------------

module ldpc_cnode_restore
  import ldpc_cnode_pkg::*;
(
  input  logic   iclk,
  input  logic   ireset,
  input  logic   idone,
  input  idx_t   ilen,
  input  mag_t   imin1     [cZC],
  input  mag_t   imin2     [cZC],
  input  idx_t   imin1_idx [cZC],
  input  zdat_t  isign,
  output logic   oread,
  input  logic   irval,
  input  zdat_t  irsign,
  input  shift_t irshift,
  output logic   oval,
  output znode_t ocnode,
  output shift_t oshift
);

  // ------------------------------
  // read control
  // ------------------------------

  logic rd_act;     // reads pending after the first one
  idx_t rd_cnt;
  idx_t rd_idx;
  idx_t len_m1;
  idx_t cur_len;
  idx_t ret_idx;    // beat index of the data coming back

  assign oread   = idone | rd_act;  // first read issued in the done cycle
  assign rd_idx  = idone ? '0   : rd_cnt;
  assign cur_len = idone ? ilen : len_m1;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      rd_act <= 1'b0;
      rd_cnt <= '0;
    end else if (oread) begin
      rd_act <= (rd_idx != cur_len);
      rd_cnt <= rd_idx + 1'b1;
    end
  end

  // sort results captured here, the sort lanes move on to the next row
  mag_t  min1_r [cZC];
  mag_t  min2_r [cZC];
  idx_t  idx_r  [cZC];
  zdat_t sign_r;

  always_ff @(posedge iclk) begin
    if (idone) begin
      len_m1 <= ilen;
      min1_r <= imin1;
      min2_r <= imin2;
      idx_r  <= imin1_idx;
      sign_r <= isign;
    end
    if (oread) begin
      ret_idx <= rd_idx;    // lines up with the FIFO read latency
    end
  end

  // ------------------------------
  // message rebuild
  // ------------------------------

  for (genvar g = 0; g < cZC; g++) begin : lane
    mag_t                       sel_mag;
    logic [cMAG_W+2 : 0]        prod;      // 15 * 6 fits in 7 bits
    mag_t                       norm;
    node_t                      nmag;
    logic                       neg;

    assign sel_mag = (ret_idx == idx_r[g]) ? min2_r[g] : min1_r[g];  // own beat excluded
    assign prod    = (cMAG_W+3)'(sel_mag) * (cMAG_W+3)'(cNORM_FACTOR);
    assign norm    = mag_t'(prod >> cNORM_SHIFT);
    assign nmag    = {1'b0, norm};
    assign neg     = sign_r[g] ^ irsign[g];   // product of the other signs
    assign ocnode[g] = neg ? -nmag : nmag;
  end

  assign oval   = irval;
  assign oshift = irshift;

endmodule

//--- rtl/ldpc_dec_cnode.sv
// ------------------------------
// min-sum check-node unit top level
// input register, strobe alignment, address counter, busy
// ------------------------------

module ldpc_dec_cnode
  import ldpc_cnode_pkg::*;
(
  input  logic   iclk,
  input  logic   ireset,
  input  logic   istart,
  input  logic   ival,
  input  logic   isop,
  input  logic   ieop,
  input  shift_t ishift,
  input  znode_t ivnode,
  input  zdat_t  ivnode_hd,
  output logic   ocnode_val,
  output addr_t  ocnode_addr,
  output znode_t ocnode,
  output logic   odecfail,
  output logic   obusy
);

  // input register
  logic      in_val;
  logic      in_sop;
  logic      in_eop;
  shift_t    in_shift;
  ibs_elem_t in_dat [cZC];

  // strobes aligned to the input shifter output
  logic      al_sop;
  logic      al_eop;
  shift_t    al_shift;

  logic      ibs_oval;
  ibs_elem_t ibs_odat [cZC];

  zdat_t     sort_done;
  mag_t      sort_min1 [cZC];
  mag_t      sort_min2 [cZC];
  idx_t      sort_idx  [cZC];
  zdat_t     sort_sign;
  idx_t      sort_len  [cZC];

  zdat_t     beat_hd;
  zdat_t     beat_sign;

  logic      fifo_read;
  logic      fifo_rval;
  zdat_t     fifo_rsign;
  shift_t    fifo_rshift;
  logic      fifo_empty;

  logic      rest_val;
  znode_t    rest_cnode;
  shift_t    rest_shift;

  node_t     obs_idat [cZC];
  node_t     obs_odat [cZC];

  // ------------------------------
  // input register and alignment
  // ------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      in_val <= 1'b0;
      in_sop <= 1'b0;
      in_eop <= 1'b0;
      al_sop <= 1'b0;
      al_eop <= 1'b0;
    end else begin
      in_val <= ival;
      in_sop <= isop;
      in_eop <= ieop;
      al_sop <= in_sop;   // extra stage matches the shifter register
      al_eop <= in_eop;
    end
  end

  always_ff @(posedge iclk) begin
    in_shift <= ishift;
    al_shift <= in_shift;
    for (int i = 0; i < cZC; i++) begin
      in_dat[i] <= {ivnode_hd[i], ivnode[i]};
    end
  end

  ldpc_barrel_shifter #(
    .elem_t   (ibs_elem_t),
    .pR_SHIFT (1'b0)
  ) ibs (
    .iclk   (iclk),
    .ireset (ireset),
    .ival   (in_val),
    .idat   (in_dat),
    .ishift (in_shift),
    .oval   (ibs_oval),
    .odat   (ibs_odat)
  );

  // ------------------------------
  // sort lanes, syndrome, FIFO
  // ------------------------------

  for (genvar g = 0; g < cZC; g++) begin : sort_lane
    ldpc_sort_engine sort (
      .iclk      (iclk),
      .ireset    (ireset),
      .ival      (ibs_oval),
      .isop      (al_sop),
      .ieop      (al_eop),
      .ivnode    (ibs_odat[g].node),
      .odone     (sort_done[g]),
      .omin1     (sort_min1[g]),
      .omin2     (sort_min2[g]),
      .omin1_idx (sort_idx[g]),
      .osign     (sort_sign[g]),
      .olen      (sort_len[g])
    );

    assign beat_hd[g]   = ibs_odat[g].hd;
    assign beat_sign[g] = ibs_odat[g].node[cNODE_W-1];   // sign only kept
  end

  ldpc_syndrome_count syndrome (
    .iclk      (iclk),
    .ireset    (ireset),
    .istart    (istart),
    .ival      (ibs_oval),
    .isop      (al_sop),
    .ieop      (al_eop),
    .ivnode_hd (beat_hd),
    .odecfail  (odecfail)
  );

  ldpc_vnode_fifo vnode_fifo (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclear  (istart),
    .iwrite  (ibs_oval),
    .iwsign  (beat_sign),
    .iwshift (al_shift),
    .iread   (fifo_read),
    .orval   (fifo_rval),
    .orsign  (fifo_rsign),
    .orshift (fifo_rshift),
    .oempty  (fifo_empty)
  );

  // ------------------------------
  // restore and output shifter
  // ------------------------------

  // all lanes finish a row together, lane 0 drives the control
  ldpc_cnode_restore restore (
    .iclk      (iclk),
    .ireset    (ireset),
    .idone     (sort_done[0]),
    .ilen      (sort_len[0]),
    .imin1     (sort_min1),
    .imin2     (sort_min2),
    .imin1_idx (sort_idx),
    .isign     (sort_sign),
    .oread     (fifo_read),
    .irval     (fifo_rval),
    .irsign    (fifo_rsign),
    .irshift   (fifo_rshift),
    .oval      (rest_val),
    .ocnode    (rest_cnode),
    .oshift    (rest_shift)
  );

  always_comb begin
    for (int i = 0; i < cZC; i++) begin
      obs_idat[i] = rest_cnode[i];
    end
  end

  ldpc_barrel_shifter #(
    .elem_t   (node_t),
    .pR_SHIFT (1'b1)
  ) obs (
    .iclk   (iclk),
    .ireset (ireset),
    .ival   (rest_val),
    .idat   (obs_idat),
    .ishift (rest_shift),   // same shift, back to original lanes
    .oval   (ocnode_val),
    .odat   (obs_odat)
  );

  always_comb begin
    for (int i = 0; i < cZC; i++) begin
      ocnode[i] = obs_odat[i];
    end
  end

  // ------------------------------
  // address counter and busy
  // ------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      ocnode_addr <= '0;
      obusy       <= 1'b0;
    end else begin
      ocnode_addr <= istart ? '0 : (ocnode_addr + addr_t'(ocnode_val));
      // look ahead, the restore beat covers the output shifter cycle
      obusy       <= ibs_oval | ~fifo_empty | rest_val;
    end
  end

endmodule

//--- bench/tb_clock_gen.sv
// ------------------------------
// testbench clock and reset, 8 ns period
// reset held for 4 cycles
// ------------------------------

module tb_clock_gen (
  output logic iclk,
  output logic ireset
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int cHALF_NS      = 4;
  localparam int cRESET_CYCLES = 4;

  initial begin
    iclk   = 1'b0;
    ireset = 1'b1;
    forever #(cHALF_NS) iclk = ~iclk;
  end

  // release on a falling edge, away from the DUT's sampling edge
  initial begin
    repeat (cRESET_CYCLES) @(posedge iclk);
    @(negedge iclk);
    ireset = 1'b0;
  end

endmodule

//--- bench/ldpc_dec_cnode_props.sv
// ------------------------------
// concurrent checks on the check-node outputs
// bound into ldpc_dec_cnode
// ------------------------------

module ldpc_dec_cnode_props
  import ldpc_cnode_pkg::*;
(
  input logic  iclk,
  input logic  ireset,
  input logic  istart,
  input logic  ocnode_val,
  input addr_t ocnode_addr,
  input logic  odecfail,
  input logic  obusy
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;   // failed assertions so far

  // ------------------------------
  // quiet right after reset
  // ------------------------------
  a_reset_low : assert property (@(posedge iclk)
    $fell(ireset) |-> !ocnode_val && !obusy && !odecfail && (ocnode_addr == '0))
    else begin
      fail_cnt++;
      $error("outputs not low after reset");
    end

  // address only moves with an output beat, istart restarts it
  a_addr_hold : assert property (@(posedge iclk) disable iff (ireset)
    (!ocnode_val && !istart) |=> $stable(ocnode_addr))
    else begin
      fail_cnt++;
      $error("ocnode_addr moved without ocnode_val");
    end

  a_addr_step : assert property (@(posedge iclk) disable iff (ireset)
    (ocnode_val && !istart) |=> (ocnode_addr == addr_t'($past(ocnode_addr) + 1'b1)))
    else begin
      fail_cnt++;
      $error("ocnode_addr did not step after ocnode_val");
    end

  a_busy_cover : assert property (@(posedge iclk) disable iff (ireset)
    ocnode_val |-> obusy)          // look-ahead busy spans every output beat
    else begin
      fail_cnt++;
      $error("obusy low during ocnode_val");
    end

endmodule

bind ldpc_dec_cnode ldpc_dec_cnode_props props (
  .iclk        (iclk),
  .ireset      (ireset),
  .istart      (istart),
  .ocnode_val  (ocnode_val),
  .ocnode_addr (ocnode_addr),
  .odecfail    (odecfail),
  .obusy       (obusy)
);

//--- bench/tb_ldpc_dec_cnode.sv
// ------------------------------
// directed tests for the min-sum check-node unit
// reference model, compare tasks, closing verdict
// ------------------------------

module tb_ldpc_dec_cnode
  import ldpc_cnode_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int cRESET_LIMIT = 20;    // cycles
  localparam int cDRAIN_LIMIT = 200;

  logic   iclk;
  logic   ireset;
  logic   istart;
  logic   ival;
  logic   isop;
  logic   ieop;
  shift_t ishift;
  znode_t ivnode;
  zdat_t  ivnode_hd;
  logic   ocnode_val;
  addr_t  ocnode_addr;
  znode_t ocnode;
  logic   odecfail;
  logic   obusy;

  // row under construction, one entry per beat
  znode_t row_msg   [cROW_MAX];
  shift_t row_shift [cROW_MAX];
  zdat_t  row_hd    [cROW_MAX];

  znode_t      exp_q [$];   // predicted output beats in order
  addr_t       exp_addr;
  logic [31:0] lcg_state;
  int          val_errs;
  int          proto_errs;
  int          tmo_errs;
  int          asrt_errs;   // failed concurrent assertions in the bound checker
  bit          aborted;     // set by a timeout, later tests skipped

  tb_clock_gen clk_gen (
    .iclk   (iclk),
    .ireset (ireset)
  );

  ldpc_dec_cnode DUT (
    .iclk        (iclk),
    .ireset      (ireset),
    .istart      (istart),
    .ival        (ival),
    .isop        (isop),
    .ieop        (ieop),
    .ishift      (ishift),
    .ivnode      (ivnode),
    .ivnode_hd   (ivnode_hd),
    .ocnode_val  (ocnode_val),
    .ocnode_addr (ocnode_addr),
    .ocnode      (ocnode),
    .odecfail    (odecfail),
    .obusy       (obusy)
  );

  // ------------------------------
  // compare tasks
  // ------------------------------

  task automatic check_znode(input string name, input znode_t got, input znode_t exp);
    if (got !== exp) begin
      val_errs++;
      $display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      val_errs++;
      $display("error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      val_errs++;
      $display("error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // ------------------------------
  // stimulus helpers and model
  // ------------------------------

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int mag_of(input node_t v);
    int iv;
    iv = v;                                     // sign extended
    if (iv == -16) return 15;                   // saturate the most negative code
    return (iv < 0) ? -iv : iv;
  endfunction

  // each message excludes its own beat: min of the others, xor of the other signs
  task automatic predict_row(input int len);
    node_t  rot [cROW_MAX][cZC];
    node_t  msg [cZC];
    znode_t beat_out;
    int     m;
    int     nv;
    logic   s;
    for (int b = 0; b < len; b++) begin
      for (int i = 0; i < cZC; i++) begin
        rot[b][i] = row_msg[b][(i + int'(row_shift[b])) % cZC];   // rotate left
      end
    end
    for (int b = 0; b < len; b++) begin
      for (int g = 0; g < cZC; g++) begin
        m = 15;
        s = 1'b0;
        for (int k = 0; k < len; k++) begin
          if (k != b) begin
            if (mag_of(rot[k][g]) < m) m = mag_of(rot[k][g]);
            s ^= rot[k][g][cNODE_W-1];
          end
        end
        nv     = (m * cNORM_FACTOR) / 8;          // six eighths, truncated
        msg[g] = s ? node_t'(-nv) : node_t'(nv);
      end
      for (int i = 0; i < cZC; i++) begin
        beat_out[i] = msg[(i - int'(row_shift[b]) + cZC) % cZC];  // rotate back right
      end
      exp_q.push_back(beat_out);
    end
  endtask

  task automatic fill_random_row(input int len, input bit rand_shift);
    logic [31:0] r;
    for (int b = 0; b < len; b++) begin
      for (int i = 0; i < cZC; i++) begin
        r = lcg_next();
        row_msg[b][i] = node_t'(r[31:27]);        // upper bits, the low ones repeat
      end
      r = lcg_next();
      row_shift[b] = rand_shift ? shift_t'(r[30:28]) : '0;
      row_hd[b]    = '0;
    end
  endtask

  task automatic send_row(input int len);
    predict_row(len);
    for (int b = 0; b < len; b++) begin
      @(negedge iclk);
      ival      = 1'b1;
      isop      = (b == 0);
      ieop      = (b == len - 1);
      ishift    = row_shift[b];
      ivnode    = row_msg[b];
      ivnode_hd = row_hd[b];
    end
  endtask

  task automatic go_idle();
    @(negedge iclk);
    ival = 1'b0;
    isop = 1'b0;
    ieop = 1'b0;
  endtask

  task automatic pulse_start();
    @(negedge iclk);
    istart   = 1'b1;
    exp_addr = '0;
    @(negedge iclk);
    istart   = 1'b0;
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    while (ireset !== 1'b0 && n < cRESET_LIMIT) begin
      @(negedge iclk);
      n++;
    end
    if (ireset !== 1'b0) begin
      tmo_errs++;
      aborted = 1'b1;
      $display("timeout: reset never released");
    end
  endtask

  task automatic wait_drain(input string what);
    int n;
    n = 0;
    while ((exp_q.size() != 0 || obusy) && n < cDRAIN_LIMIT) begin
      @(negedge iclk);
      n++;
    end
    if (exp_q.size() != 0 || obusy) begin
      tmo_errs++;
      aborted = 1'b1;
      $display("timeout: %s did not drain, %0d output beats never came", what, exp_q.size());
    end
  endtask

  // ------------------------------
  // output monitor
  // ------------------------------

  always @(negedge iclk) begin
    if (!ireset && ocnode_val === 1'b1) begin
      if (exp_q.size() == 0) begin
        proto_errs++;
        $display("output beat at %0d ns that no input row predicts", $time);
      end else begin
        check_znode("ocnode", ocnode, exp_q.pop_front());
        check_addr("ocnode_addr", ocnode_addr, exp_addr);
        exp_addr++;
      end
    end
  end

  // ------------------------------
  // directed tests
  // ------------------------------

  task automatic test_reset_quiet();
    repeat (12) begin
      @(negedge iclk);
      check_bit("ocnode_val", ocnode_val, 1'b0);
      check_bit("obusy", obusy, 1'b0);
      check_bit("odecfail", odecfail, 1'b0);
    end
  endtask

  task automatic test_single_row();
    pulse_start();
    for (int b = 0; b < 4; b++) begin
      for (int i = 0; i < cZC; i++) begin
        row_msg[b][i] = node_t'(((i * 5 + b * 3) % 16) - 8);   // mixed signs, some ties
      end
      row_shift[b] = '0;
      row_hd[b]    = '0;
    end
    send_row(4);
    go_idle();
    wait_drain("single row");
  endtask

  task automatic test_shifted_rows();
    pulse_start();
    for (int r = 0; r < 2; r++) begin
      fill_random_row(5, 1'b0);
      for (int b = 0; b < 5; b++) begin
        row_shift[b] = shift_t'(b * 3 + r + 1);   // never zero on the first beat
      end
      send_row(5);
    end
    go_idle();
    wait_drain("shifted rows");
  endtask

  task automatic test_random_stream();
    pulse_start();
    for (int r = 0; r < 6; r++) begin
      fill_random_row(6, 1'b1);
      send_row(6);                                  // back to back
    end
    go_idle();
    wait_drain("random stream");
    check_addr("ocnode_addr", ocnode_addr, addr_t'(36));
    pulse_start();
    check_addr("ocnode_addr", ocnode_addr, '0);
    for (int r = 0; r < 2; r++) begin
      fill_random_row(3, 1'b1);
      send_row(3);
    end
    go_idle();
    wait_drain("stream after restart");
  endtask

  task automatic test_decfail();
    pulse_start();
    check_bit("odecfail", odecfail, 1'b0);
    fill_random_row(4, 1'b1);
    row_hd[0] = 8'h08;                              // single bit, one lane goes odd
    send_row(4);
    fill_random_row(4, 1'b1);                       // even row after it, flag must stick
    send_row(4);
    go_idle();
    wait_drain("odd parity row");
    check_bit("odecfail", odecfail, 1'b1);
    pulse_start();
    check_bit("odecfail", odecfail, 1'b0);
    fill_random_row(4, 1'b0);
    for (int b = 0; b < 4; b++) begin
      row_hd[b] = 8'ha5;                            // even count per lane with no shift
    end
    send_row(4);
    go_idle();
    wait_drain("even parity row");
    check_bit("odecfail", odecfail, 1'b0);
  endtask

  initial begin : main
    istart     = 1'b0;
    ival       = 1'b0;
    isop       = 1'b0;
    ieop       = 1'b0;
    ishift     = '0;
    ivnode     = '0;
    ivnode_hd  = '0;
    exp_addr   = '0;
    lcg_state  = 32'h1bd2_a4bb;
    val_errs   = 0;
    proto_errs = 0;
    tmo_errs   = 0;
    asrt_errs  = 0;
    aborted    = 1'b0;
    wait_reset();
    if (!aborted) test_reset_quiet();
    if (!aborted) test_single_row();
    if (!aborted) test_shifted_rows();
    if (!aborted) test_random_stream();
    if (!aborted) test_decfail();
    asrt_errs = DUT.props.fail_cnt;
    $display("errors: %0d value, %0d protocol, %0d timeout, %0d assertion",
             val_errs, proto_errs, tmo_errs, asrt_errs);
    if (val_errs + proto_errs + tmo_errs + asrt_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- all.f
rtl/ldpc_cnode_pkg.sv
rtl/ldpc_barrel_shifter.sv
rtl/ldpc_sort_engine.sv
rtl/ldpc_syndrome_count.sv
rtl/ldpc_vnode_fifo.sv
rtl/ldpc_cnode_restore.sv
rtl/ldpc_dec_cnode.sv
bench/tb_clock_gen.sv
bench/ldpc_dec_cnode_props.sv
bench/tb_ldpc_dec_cnode.sv

//--- Bender.yml
package:
  name: ldpc_dec_cnode

sources:
  - rtl/ldpc_cnode_pkg.sv
  - rtl/ldpc_barrel_shifter.sv
  - rtl/ldpc_sort_engine.sv
  - rtl/ldpc_syndrome_count.sv
  - rtl/ldpc_vnode_fifo.sv
  - rtl/ldpc_cnode_restore.sv
  - rtl/ldpc_dec_cnode.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/ldpc_dec_cnode_props.sv
      - bench/tb_ldpc_dec_cnode.sv
